//--- Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_core_id_ex
FILELIST := filelist.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then exit 1; fi
	@grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- filelist.f
+incdir+source
source/rv_pkg.sv
source/id_ex_if.sv
source/reg_file.sv
source/inst_decode.sv
source/register_id_ex.sv
source/exec_stage.sv
source/core_id_ex_top.sv
testbench/tb_clock_gen.sv
testbench/tb_core_id_ex.sv

//--- source/core_id_ex_top.sv
// --------------------
// Decode and execute slice: register file, decode, ID/EX and execute.
// --------------------
`timescale 1ns/1ps
`include "rv_params.svh"

module core_id_ex_top (
    input  logic                      reg_id_ex_wiring,
    input  logic                      arst_n,
    input  logic                      in_valid,
    input  logic [31:0]               in_instr,
    input  logic [`RV_XLEN-1:0]       in_pc,
    input  logic                      flush,
    output logic                      out_valid,
    output logic [`RV_REG_ADDR_W-1:0] out_rd,
    output logic [`RV_XLEN-1:0]       out_result,
    output logic                      redirect_valid,
    output logic [`RV_XLEN-1:0]       redirect_pc
);

    logic [`RV_REG_ADDR_W-1:0] rs1_addr;
    logic [`RV_REG_ADDR_W-1:0] rs2_addr;
    logic [`RV_XLEN-1:0]       rs1_data;
    logic [`RV_XLEN-1:0]       rs2_data;
    logic                      wr_en;
    logic [`RV_REG_ADDR_W-1:0] wr_addr;
    logic [`RV_XLEN-1:0]       wr_data;
    logic                      kill;

    // Decode to ID/EX, then ID/EX to execute.
    id_ex_if id_bus ();
    id_ex_if ex_bus ();

    reg_file u_reg_file (
        .reg_id_ex_wiring (reg_id_ex_wiring),
        .arst_n           (arst_n),
        .rs1_addr         (rs1_addr),
        .rs2_addr         (rs2_addr),
        .wr_en            (wr_en),
        .wr_addr          (wr_addr),
        .wr_data          (wr_data),
        .rs1_data         (rs1_data),
        .rs2_data         (rs2_data)
    );

    inst_decode u_inst_decode (
        .in_valid (in_valid),
        .in_instr (in_instr),
        .in_pc    (in_pc),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .id_bus   (id_bus.source)
    );

    register_id_ex u_register_id_ex (
        .reg_id_ex_wiring (reg_id_ex_wiring),
        .arst_n           (arst_n),
        .flush            (flush),
        .kill             (kill),
        .id_bus           (id_bus.sink),
        .ex_bus           (ex_bus.source)
    );

    exec_stage u_exec_stage (
        .reg_id_ex_wiring (reg_id_ex_wiring),
        .arst_n           (arst_n),
        .ex_bus           (ex_bus.sink),
        .wr_en            (wr_en),
        .wr_addr          (wr_addr),
        .wr_data          (wr_data),
        .kill             (kill),
        .out_valid        (out_valid),
        .out_rd           (out_rd),
        .out_result       (out_result),
        .redirect_valid   (redirect_valid),
        .redirect_pc      (redirect_pc)
    );

endmodule

//--- source/exec_stage.sv
// --------------------
// Execute stage: ALU, branch compare, registered result and redirect.
// --------------------
`timescale 1ns/1ps
`include "rv_params.svh"

module exec_stage (
    input  logic                      reg_id_ex_wiring,
    input  logic                      arst_n,
    id_ex_if.sink                     ex_bus,
    output logic                      wr_en,
    output logic [`RV_REG_ADDR_W-1:0] wr_addr,
    output logic [`RV_XLEN-1:0]       wr_data,
    output logic                      kill,
    output logic                      out_valid,
    output logic [`RV_REG_ADDR_W-1:0] out_rd,
    output logic [`RV_XLEN-1:0]       out_result,
    output logic                      redirect_valid,
    output logic [`RV_XLEN-1:0]       redirect_pc
);
    import rv_pkg::*;

    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] op_b;
    logic [`RV_XLEN-1:0] alu_result;
    logic [`RV_XLEN-1:0] target;
    logic [4:0]          shamt;
    logic                cond;

    assign op_a  = ex_bus.rs1_data;
    assign op_b  = ex_bus.ex.alu_src_imm ? ex_bus.imm : ex_bus.rs2_data;
    assign shamt = op_b[4:0];

    always_comb begin
        case (ex_bus.ex.alu_op)
            ADD:     alu_result = op_a + op_b;
            SUB:     alu_result = op_a - op_b;
            AND:     alu_result = op_a & op_b;
            OR:      alu_result = op_a | op_b;
            XOR:     alu_result = op_a ^ op_b;
            SLT:     alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
            SLTU:    alu_result = {31'b0, op_a < op_b};
            SLL:     alu_result = op_a << shamt;
            SRL:     alu_result = op_a >> shamt;
            SRA:     alu_result = $unsigned($signed(op_a) >>> shamt);
            default: alu_result = op_b;
        endcase
    end

    // Branch compare always uses rs2, never the immediate.
    always_comb begin
        case (ex_bus.ex.funct3)
            3'b000:  cond = (op_a == ex_bus.rs2_data);
            3'b001:  cond = (op_a != ex_bus.rs2_data);
            3'b100:  cond = ($signed(op_a) < $signed(ex_bus.rs2_data));
            3'b101:  cond = ($signed(op_a) >= $signed(ex_bus.rs2_data));
            default: cond = 1'b0;
        endcase
    end

    assign target = ex_bus.pc + ex_bus.imm;
    assign kill   = ex_bus.valid && ex_bus.ex.is_branch && cond;

    // Write-back goes to the register file at the end of this cycle.
    assign wr_en   = ex_bus.valid && !ex_bus.ex.is_branch && ex_bus.wb.reg_write;
    assign wr_addr = ex_bus.rd;
    assign wr_data = alu_result;

    always_ff @(posedge reg_id_ex_wiring or negedge arst_n) begin
        if (!arst_n) begin
            out_valid      <= 1'b0;
            out_rd         <= '0;
            out_result     <= '0;
            redirect_valid <= 1'b0;
            redirect_pc    <= '0;
        end else begin
            out_valid      <= wr_en;
            out_rd         <= wr_addr;
            out_result     <= wr_data;
            redirect_valid <= kill;
            redirect_pc    <= target;
        end
    end

endmodule

//--- source/id_ex_if.sv
// --------------------
// One decoded instruction as it moves from decode towards execute.
// --------------------
`timescale 1ns/1ps
`include "rv_params.svh"

interface id_ex_if;
    import rv_pkg::*;

    // Set when the slot holds a real instruction.
    logic                      valid;

    // Program counter of the instruction.
    logic [`RV_XLEN-1:0]       pc;

    // Operands as read from the register file.
    logic [`RV_XLEN-1:0]       rs1_data;
    logic [`RV_XLEN-1:0]       rs2_data;

    // Sign-extended or shifted immediate.
    logic [`RV_XLEN-1:0]       imm;

    // Destination register index.
    logic [`RV_REG_ADDR_W-1:0] rd;

    // Control groups.
    ex_ctrl_t                  ex;
    wb_ctrl_t                  wb;

    // Producer side.
    modport source (
        output valid, pc, rs1_data, rs2_data, imm, rd, ex, wb
    );

    // Consumer side.
    modport sink (
        input valid, pc, rs1_data, rs2_data, imm, rd, ex, wb
    );

endinterface

//--- source/inst_decode.sv
// --------------------
// Instruction decode: operand read, immediate and control generation.
// --------------------
`timescale 1ns/1ps
`include "rv_params.svh"

module inst_decode (
    input  logic                      in_valid,
    input  logic [31:0]               in_instr,
    input  logic [`RV_XLEN-1:0]       in_pc,
    input  logic [`RV_XLEN-1:0]       rs1_data,
    input  logic [`RV_XLEN-1:0]       rs2_data,
    output logic [`RV_REG_ADDR_W-1:0] rs1_addr,
    output logic [`RV_REG_ADDR_W-1:0] rs2_addr,
    id_ex_if.source                   id_bus
);
    import rv_pkg::*;

    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic                funct7_b5;
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_u;
    logic [`RV_XLEN-1:0] imm_b;

    // Shared funct3 map for register and immediate ALU forms.
    // alt picks sub over add and sra over srl.
    function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'b000:  op = alt ? SUB : ADD;
            3'b001:  op = SLL;
            3'b010:  op = SLT;
            3'b011:  op = SLTU;
            3'b100:  op = XOR;
            3'b101:  op = alt ? SRA : SRL;
            3'b110:  op = OR;
            default: op = AND;
        endcase
        return op;
    endfunction

    assign opcode    = in_instr[6:0];
    assign funct3    = in_instr[14:12];
    assign funct7_b5 = in_instr[30];

    assign rs1_addr  = in_instr[19:15];
    assign rs2_addr  = in_instr[24:20];

    // Immediate formats.
    assign imm_i = {{20{in_instr[31]}}, in_instr[31:20]};
    assign imm_u = {in_instr[31:12], 12'b0};
    assign imm_b = {{19{in_instr[31]}}, in_instr[31], in_instr[7],
                    in_instr[30:25], in_instr[11:8], 1'b0};

    always_comb begin
        // Anything not matched below leaves a bubble.
        id_bus.valid          = 1'b0;
        id_bus.pc             = in_pc;
        id_bus.rs1_data       = rs1_data;
        id_bus.rs2_data       = rs2_data;
        id_bus.rd             = in_instr[11:7];
        id_bus.imm            = imm_i;
        id_bus.ex.alu_op      = ADD;
        id_bus.ex.alu_src_imm = 1'b0;
        id_bus.ex.is_branch   = 1'b0;
        id_bus.ex.funct3      = funct3;
        id_bus.wb.reg_write   = 1'b0;

        case (opcode)
            OP: begin
                id_bus.valid        = in_valid;
                id_bus.ex.alu_op    = alu_sel(funct3, funct7_b5);
                id_bus.wb.reg_write = 1'b1;
            end
            OP_IMM: begin
                // Bit 30 belongs to the immediate except for the shifts.
                id_bus.valid          = in_valid;
                id_bus.ex.alu_op      = alu_sel(funct3, (funct3 == 3'b101) && funct7_b5);
                id_bus.ex.alu_src_imm = 1'b1;
                id_bus.wb.reg_write   = 1'b1;
            end
            LUI: begin
                id_bus.valid          = in_valid;
                id_bus.imm            = imm_u;
                id_bus.ex.alu_op      = PASS_B;
                id_bus.ex.alu_src_imm = 1'b1;
                id_bus.wb.reg_write   = 1'b1;
            end
            BRANCH: begin
                // Only beq, bne, blt and bge are supported.
                id_bus.valid        = in_valid && (funct3 inside {3'b000, 3'b001, 3'b100, 3'b101});
                id_bus.imm          = imm_b;
                id_bus.ex.is_branch = 1'b1;
            end
            default: begin
                id_bus.valid = 1'b0;
            end
        endcase
    end

endmodule

//--- source/reg_file.sv
// --------------------
// Integer register file, 32 x 32 bits, two read ports and one write port.
// --------------------
`timescale 1ns/1ps
`include "rv_params.svh"

module reg_file (
    input  logic                      reg_id_ex_wiring,
    input  logic                      arst_n,
    input  logic [`RV_REG_ADDR_W-1:0] rs1_addr,
    input  logic [`RV_REG_ADDR_W-1:0] rs2_addr,
    input  logic                      wr_en,
    input  logic [`RV_REG_ADDR_W-1:0] wr_addr,
    input  logic [`RV_XLEN-1:0]       wr_data,
    output logic [`RV_XLEN-1:0]       rs1_data,
    output logic [`RV_XLEN-1:0]       rs2_data
);

    logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];

    // Synchronous write.
    // x0 is cleared by reset and never written, so it reads as zero.
    always_ff @(posedge reg_id_ex_wiring or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Asynchronous read.
    // A write and a read of the same register in one cycle return the old value.
    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

endmodule

//--- source/register_id_ex.sv
// --------------------
// ID/EX pipeline register with valid bit, flush and branch kill.
// --------------------
`timescale 1ns/1ps

module register_id_ex (
    input  logic     reg_id_ex_wiring,
    input  logic     arst_n,
    input  logic     flush,
    input  logic     kill,
    id_ex_if.sink    id_bus,
    id_ex_if.source  ex_bus
);

    // Valid bit.
    // A flush or a taken branch in execute squashes the incoming slot.
    always_ff @(posedge reg_id_ex_wiring or negedge arst_n) begin
        if (!arst_n) begin
            ex_bus.valid <= 1'b0;
        end else begin
            ex_bus.valid <= id_bus.valid && !flush && !kill;
        end
    end

    // Payload and control groups, captured every cycle.
    always_ff @(posedge reg_id_ex_wiring or negedge arst_n) begin
        if (!arst_n) begin
            ex_bus.pc       <= '0;
            ex_bus.rs1_data <= '0;
            ex_bus.rs2_data <= '0;
            ex_bus.imm      <= '0;
            ex_bus.rd       <= '0;
            ex_bus.ex       <= '0;
            ex_bus.wb       <= '0;
        end else begin
            ex_bus.pc       <= id_bus.pc;
            ex_bus.rs1_data <= id_bus.rs1_data;
            ex_bus.rs2_data <= id_bus.rs2_data;
            ex_bus.imm      <= id_bus.imm;
            ex_bus.rd       <= id_bus.rd;
            ex_bus.ex       <= id_bus.ex;
            ex_bus.wb       <= id_bus.wb;
        end
    end

endmodule

//--- source/rv_params.svh
// --------------------
// Fixed RV32I widths for the decode and execute slice.
// --------------------
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// Data and pc width.
`define RV_XLEN       32

// Architectural register count and index width.
`define RV_REG_COUNT  32
`define RV_REG_ADDR_W 5

`endif

//--- source/rv_pkg.sv
// --------------------
// RV32I slice types: opcodes, ALU operations and control groups.
// --------------------
package rv_pkg;

    // Major opcodes handled by the decoder.
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        BRANCH = 7'b1100011
    } opcode_e;

    // ALU operations.
    // PASS_B forwards the second operand, used by lui.
    typedef enum logic [3:0] {
        ADD    = 4'd0,
        SUB    = 4'd1,
        AND    = 4'd2,
        OR     = 4'd3,
        XOR    = 4'd4,
        SLT    = 4'd5,
        SLTU   = 4'd6,
        SLL    = 4'd7,
        SRL    = 4'd8,
        SRA    = 4'd9,
        PASS_B = 4'd10
    } alu_op_e;

    // Execute control group.
    // funct3 selects the branch comparison when is_branch is set.
    typedef struct packed {
        alu_op_e    alu_op;
        logic       alu_src_imm;
        logic       is_branch;
        logic [2:0] funct3;
    } ex_ctrl_t;

    // Write-back control group.
    typedef struct packed {
        logic reg_write;
    } wb_ctrl_t;

endpackage

//--- testbench/tb_clock_gen.sv
// --------------------
// Testbench clock and reset source.
// --------------------
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset held for three rising edges.
    initial begin
        arst_n = 1'b0;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
    end

endmodule

//--- testbench/tb_core_id_ex.sv
// --------------------
// Testbench for the decode and execute slice with a reference register model.
// --------------------
`timescale 1ns/1ps

module tb_core_id_ex;

    logic        clk;
    logic        arst_n;
    logic        in_valid;
    logic [31:0] in_instr;
    logic [31:0] in_pc;
    logic        flush;
    logic        out_valid;
    logic [4:0]  out_rd;
    logic [31:0] out_result;
    logic        redirect_valid;
    logic [31:0] redirect_pc;

    // Expectations for the instruction issued at the same edge.
    logic        exp_out = 1'b0;
    logic [31:0] exp_res = '0;
    logic [4:0]  exp_rd = '0;
    logic        exp_redir = 1'b0;
    logic [31:0] exp_rpc = '0;
    // Same expectations delayed by two cycles.
    logic [1:0]  iv_d = '0;
    logic [1:0]  out_d = '0;
    logic [1:0]  redir_d = '0;
    logic [31:0] res_d [2];
    logic [4:0]  rd_d [2];
    logic [31:0] rpc_d [2];

    logic [31:0] ref_regs [32];
    logic [15:0] lfsr = 16'd89;
    string       test_name = "reset";
    int          mismatch_count = 0;
    int          other_count = 0;

    tb_clock_gen u_clock_gen (.clk(clk), .arst_n(arst_n));

    core_id_ex_top uut (
        .reg_id_ex_wiring (clk),
        .arst_n           (arst_n),
        .in_valid         (in_valid),
        .in_instr         (in_instr),
        .in_pc            (in_pc),
        .flush            (flush),
        .out_valid        (out_valid),
        .out_rd           (out_rd),
        .out_result       (out_result),
        .redirect_valid   (redirect_valid),
        .redirect_pc      (redirect_pc)
    );

    always @(posedge clk) begin
        iv_d     <= {iv_d[0], in_valid};
        out_d    <= {out_d[0], exp_out};
        redir_d  <= {redir_d[0], exp_redir};
        res_d[0] <= exp_res;
        res_d[1] <= res_d[0];
        rd_d[0]  <= exp_rd;
        rd_d[1]  <= rd_d[0];
        rpc_d[0] <= exp_rpc;
        rpc_d[1] <= rpc_d[0];
    end

    // Result and redirect strobes land exactly two cycles after the issue.
    a_out_valid: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid == (iv_d[1] && out_d[1]))
        else begin
            mismatch_count++;
            $display("MISMATCH %s out_valid expected %0b actual %0b", test_name,
                     $sampled(iv_d[1] && out_d[1]), $sampled(out_valid));
        end
    a_out_data: assert property (@(posedge clk) disable iff (!arst_n)
        (iv_d[1] && out_d[1]) |-> (out_result == res_d[1] && out_rd == rd_d[1]))
        else begin
            mismatch_count++;
            $display("MISMATCH %s result expected x%0d=%h actual x%0d=%h", test_name,
                     $sampled(rd_d[1]), $sampled(res_d[1]), $sampled(out_rd),
                     $sampled(out_result));
        end
    a_redirect_valid: assert property (@(posedge clk) disable iff (!arst_n)
        redirect_valid == (iv_d[1] && redir_d[1]))
        else begin
            mismatch_count++;
            $display("MISMATCH %s redirect_valid expected %0b actual %0b", test_name,
                     $sampled(iv_d[1] && redir_d[1]), $sampled(redirect_valid));
        end
    a_redirect_pc: assert property (@(posedge clk) disable iff (!arst_n)
        (iv_d[1] && redir_d[1]) |-> redirect_pc == rpc_d[1])
        else begin
            mismatch_count++;
            $display("MISMATCH %s redirect_pc expected %h actual %h", test_name,
                     $sampled(rpc_d[1]), $sampled(redirect_pc));
        end

    // Fibonacci LFSR with taps 16 14 13 11, stepped once per bit taken.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // Reference ALU where alt selects sub and sra.
    function automatic logic [31:0] model_alu(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    task automatic drive_issue(input logic [31:0] instr, input logic [31:0] pc,
                               input logic eo, input logic [31:0] er, input logic [4:0] erd,
                               input logic ed, input logic [31:0] epc, input logic fl);
        @(posedge clk);
        in_valid  <= 1'b1;
        in_instr  <= instr;
        in_pc     <= pc;
        flush     <= fl;
        exp_out   <= eo;
        exp_res   <= er;
        exp_rd    <= erd;
        exp_redir <= ed;
        exp_rpc   <= epc;
    endtask

    // Ends the strobe, then waits for a result or lets the slot drain.
    task automatic finish_issue(input logic expect_any);
        int n;
        n = 0;
        @(posedge clk);
        in_valid <= 1'b0;
        flush    <= 1'b0;
        exp_out  <= 1'b0;
        exp_redir <= 1'b0;
        @(negedge clk);
        while (expect_any && !(out_valid || redirect_valid) && n < 4) begin
            @(negedge clk);
            n++;
        end
        if (expect_any && n >= 4) begin
            other_count++;
            $display("Timeout in %s: no result or redirect arrived", test_name);
        end
        while (n < 1) begin
            @(negedge clk);
            n++;
        end
    endtask

    task automatic run_alu(input logic [31:0] instr, input logic [4:0] rd,
                           input logic [31:0] res);
        drive_issue(instr, 32'h100, 1'b1, res, rd, 1'b0, '0, 1'b0);
        finish_issue(1'b1);
        if (rd != 0) ref_regs[rd] = res;
    endtask

    initial begin
        #100000;
        $display("Watchdog expired before the test sequence completed");
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        logic [31:0] v;
        logic [31:0] b;
        logic [31:0] pc;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [11:0] imm;
        int          n;
        in_valid = 1'b0;
        in_instr = '0;
        in_pc    = '0;
        flush    = 1'b0;
        for (int i = 0; i < 32; i++) ref_regs[i] = '0;
        n = 0;
        while (!arst_n && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (!arst_n) begin
            other_count++;
            $display("Reset never released");
        end
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            if (out_valid || redirect_valid) begin
                other_count++;
                $display("Output strobe active after reset with nothing issued");
            end
        end

        test_name = "lui";
        // Odd registers get a negative value and even ones a positive value.
        for (int i = 1; i <= 8; i++) begin
            v     = rand_bits(20);
            v[19] = i[0];
            run_alu({v[19:0], 5'(i), 7'h37}, 5'(i), {v[19:0], 12'b0});
        end

        test_name = "alu";
        for (int f3 = 0; f3 < 8; f3++) begin
            for (int alt = 0; alt < 2; alt++) begin
                if (alt == 0 || f3 == 0 || f3 == 5) begin
                    v   = rand_bits(3);
                    rs1 = 5'(v[2:0] + 1);
                    // Compares and right shifts start from a negative rs1.
                    if (f3 == 2 || f3 == 3 || f3 == 5) begin
                        rs1 = 5'({v[1:0], 1'b1});
                    end
                    v   = rand_bits(3);
                    rs2 = 5'(v[2:0] + 1);
                    // A positive rs2 splits signed from unsigned compare.
                    // Register shifts take their amount from x17.
                    if (f3 == 2 || f3 == 3) begin
                        rs2 = 5'({v[1:0], 1'b0} + 2);
                    end else if (f3 == 1 || f3 == 5) begin
                        rs2 = 5'd17;
                    end
                    rd  = 5'(9 + f3);
                    run_alu({1'b0, alt[0], 5'b0, rs2, rs1, f3[2:0], rd, 7'h33}, rd,
                            model_alu(f3[2:0], alt[0], ref_regs[rs1], ref_regs[rs2]));
                end
                if (alt == 0 || f3 == 5) begin
                    v   = rand_bits(12);
                    imm = v[11:0];
                    // Odd low bits in x17 give the register shifts a nonzero amount.
                    if (f3 == 0) begin
                        imm[0] = 1'b1;
                    end else if (f3 == 2 || f3 == 3) begin
                        imm[11] = 1'b0;
                    end else if (f3 == 1 || f3 == 5) begin
                        imm = {1'b0, alt[0], 5'b0, v[4:1], 1'b1};
                    end
                    v   = rand_bits(3);
                    rs1 = 5'(v[2:0] + 1);
                    if (f3 == 2 || f3 == 3 || f3 == 5) begin
                        rs1 = 5'({v[1:0], 1'b1});
                    end
                    rd  = 5'(17 + f3);
                    b   = {{20{imm[11]}}, imm};
                    run_alu({imm, rs1, f3[2:0], rd, 7'h13}, rd,
                            model_alu(f3[2:0], alt[0], ref_regs[rs1], b));
                end
            end
        end

        test_name = "x0";
        run_alu({12'h123, 5'd1, 3'd0, 5'd0, 7'h13}, 5'd0, ref_regs[1] + 32'h123);
        run_alu({7'b0, 5'd0, 5'd0, 3'd0, 5'd25, 7'h33}, 5'd25, 32'd0);

        test_name = "branch";
        v  = rand_bits(12);
        pc = 32'h2000 + {18'b0, v[11:0], 2'b0};
        v  = rand_bits(12);
        b  = {{19{v[11]}}, v[11:0], 1'b0};
        drive_issue(enc_b(b[12:0], 5'd1, 5'd1, 3'd0), pc, 1'b0, '0, '0, 1'b1, pc + b, 1'b0);
        finish_issue(1'b1);
        drive_issue(enc_b(b[12:0], 5'd1, 5'd1, 3'd1), pc, 1'b0, '0, '0, 1'b0, '0, 1'b0);
        finish_issue(1'b0);
        // x1 is negative and x2 positive, so the signed compares differ from unsigned.
        drive_issue(enc_b(b[12:0], 5'd2, 5'd1, 3'd4), pc, 1'b0, '0, '0,
                    $signed(ref_regs[1]) < $signed(ref_regs[2]), pc + b, 1'b0);
        finish_issue(1'b1);
        drive_issue(enc_b(b[12:0], 5'd1, 5'd2, 3'd4), pc, 1'b0, '0, '0,
                    $signed(ref_regs[2]) < $signed(ref_regs[1]), pc + b, 1'b0);
        finish_issue(1'b0);
        drive_issue(enc_b(b[12:0], 5'd1, 5'd2, 3'd5), pc + 4, 1'b0, '0, '0,
                    $signed(ref_regs[2]) >= $signed(ref_regs[1]), pc + 4 + b, 1'b0);
        finish_issue(1'b1);
        // Taken beq with a follower one cycle behind it.
        drive_issue(enc_b(b[12:0], 5'd3, 5'd3, 3'd0), pc, 1'b0, '0, '0, 1'b1, pc + b, 1'b0);
        drive_issue({12'h001, 5'd1, 3'd0, 5'd26, 7'h13}, pc + 4, 1'b0, '0, '0, 1'b0, '0, 1'b0);
        finish_issue(1'b1);

        test_name = "flush";
        drive_issue({12'h055, 5'd2, 3'd0, 5'd27, 7'h13}, 32'h300, 1'b0, '0, '0, 1'b0, '0, 1'b1);
        finish_issue(1'b0);
        test_name = "unsupported";
        drive_issue({12'h000, 5'd1, 3'd2, 5'd3, 7'h03}, 32'h304, 1'b0, '0, '0, 1'b0, '0, 1'b0);
        finish_issue(1'b0);
        run_alu({7'b0, 5'd0, 5'd3, 3'd0, 5'd28, 7'h33}, 5'd28, ref_regs[3]);
        run_alu({7'b0, 5'd0, 5'd27, 3'd0, 5'd29, 7'h33}, 5'd29, ref_regs[27]);

        repeat (3) @(negedge clk);
        $display("Error counts: %0d mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
